//--- verification/mfp_ahb_vectors.txt
// op size addr data expect, all hex
// op 0 write, 1 read, 2 set inputs (addr buttons, data switches), 3 random fill, 4 idle, 5 model read, 6 led check (data red, expect green), 7 fill read
0 2 00000010 DEADBEEF 00000000
1 2 00000010 00000000 DEADBEEF
0 2 00000014 11223344 00000000
0 2 00000018 55667788 00000000
1 2 00000014 00000000 11223344
1 2 00000018 00000000 55667788
0 0 00000011 0000AA00 00000000
5 2 00000010 00000000 00000000
0 1 00000012 12340000 00000000
5 2 00000010 00000000 00000000
1 2 00000010 00000000 1234AAEF
3 2 00000100 00000040 00000000
7 2 00000100 00000040 00000000
0 2 1F800000 FFFFFFFF 00000000
0 2 1F800004 000001A5 00000000
6 2 00000000 0003FFFF 000001A5
1 2 1F800000 00000000 0003FFFF
1 2 1F800004 00000000 000001A5
0 0 1F800002 00000000 00000000
1 2 1F800000 00000000 0000FFFF
2 2 00000015 0002A5A5 00000000
4 2 00000000 00000000 00000000
4 2 00000000 00000000 00000000
4 2 00000000 00000000 00000000
1 2 1F800008 00000000 0002A5A5
1 2 1F80000C 00000000 00000015
0 2 1F800008 FFFFFFFF 00000000
0 2 1F80000C FFFFFFFF 00000000
1 2 1F800008 00000000 0002A5A5
1 2 1F80000C 00000000 00000015
1 2 20000000 00000000 00000000
4 2 00000010 00000000 00000000
4 2 1F800000 00000000 00000000
1 2 00000010 00000000 1234AAEF
6 2 00000000 0000FFFF 000001A5

//--- list.f
+incdir+include
design/mfp_ahb_pkg.sv
design/mfp_ahb_ram.sv
design/mfp_ahb_gpio.sv
design/mfp_ahb_matrix.sv
design/mfp_ahb_system.sv
verification/tb_mfp_ahb_system.sv

//--- run.sh
#!/usr/bin/env bash
# build and run the AHB system testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --timing -Wall -Wno-fatal \
    -f list.f \
    --top-module tb_mfp_ahb_system \
    -o sim_tb

./obj_dir/sim_tb | tee sim.log

if grep -q "=== FAIL ===" sim.log; then
    echo "simulation failed"
    exit 1
fi

echo "simulation passed"

//--- verification/tb_mfp_ahb_system.sv
`include "mfp_ahb_map.svh"

module tb_mfp_ahb_system
    import mfp_ahb_pkg::*;
;
    timeunit 1ns;
    timeprecision 1ps;

    logic                    clk;
    logic                    rst_n;
    ahb_addr_t               haddr;
    htrans_t                 htrans;
    hsize_t                  hsize;
    logic                    hwrite;
    logic [31:0]             hwdata;
    logic [31:0]             hrdata;
    logic [switch_width-1:0] switches;
    logic [button_width-1:0] buttons;
    logic [red_width-1:0]    red_leds;
    logic [green_width-1:0]  green_leds;

    // vector table, columns op size addr data expect
    logic [3:0]  v_op   [$];
    logic [2:0]  v_size [$];
    logic [31:0] v_addr [$];
    logic [31:0] v_data [$];
    logic [31:0] v_exp  [$];

    // pending read checks, popped in their data phase
    logic [31:0] exp_q [$];
    int          cyc_q [$];
    string       name_q[$];

    logic [31:0] model [0:1023];
    logic [31:0] next_wdata;
    logic [15:0] lfsr_state;
    int          cycle;
    int          limit;
    int          pass_count;
    int          fail_count;

    mfp_ahb_system #(
        .ram_addr_width ( 10 )
    ) i_dut
    (
        .clk        ( clk        ),
        .rst_n      ( rst_n      ),
        .haddr      ( haddr      ),
        .htrans     ( htrans     ),
        .hsize      ( hsize      ),
        .hwrite     ( hwrite     ),
        .hwdata     ( hwdata     ),
        .hrdata     ( hrdata     ),
        .switches   ( switches   ),
        .buttons    ( buttons    ),
        .red_leds   ( red_leds   ),
        .green_leds ( green_leds )
    );

    initial
    begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // taps 16 14 13 11
    function automatic logic lfsr_step();
        logic fb;
        fb = lfsr_state[15] ^ lfsr_state[13] ^ lfsr_state[12] ^ lfsr_state[10];
        lfsr_state = {lfsr_state[14:0], fb};
        return fb;
    endfunction

    function automatic logic [31:0] random_word();
        logic [31:0] w;
        for (int i = 0; i < 32; i++)
            w[i] = lfsr_step();
        return w;
    endfunction

    // AHB little endian: bytes covered by the size, aligned down
    function automatic logic [31:0] apply_write(logic [31:0] old_word, logic [31:0] new_word,
                                                logic [2:0] size, logic [1:0] off);
        int nbytes;
        int first;
        logic [31:0] w;
        nbytes = (size >= 3'd2) ? 4 : (1 << size);
        first = int'(off) - (int'(off) % nbytes);
        w = old_word;
        for (int b = first; b < first + nbytes; b++)
            w[8*b +: 8] = new_word[8*b +: 8];
        return w;
    endfunction

    function automatic logic is_ram(logic [31:0] addr);
        return addr[31:`MFP_REGION_LSB] == (`MFP_RAM_BASE >> `MFP_REGION_LSB);
    endfunction

    task automatic check_rdata(string name, logic [31:0] expected, logic [31:0] actual);
        if (expected === actual)
        begin
            pass_count++;
            $display("ok %s hrdata %h", name, actual);
        end
        else
        begin
            fail_count++;
            $display("MISMATCH hrdata %s expected %h actual %h", name, expected, actual);
        end
    endtask

    task automatic check_red(logic [red_width-1:0] expected, logic [red_width-1:0] actual);
        if (expected === actual)
        begin
            pass_count++;
            $display("ok red_leds %h", actual);
        end
        else
        begin
            fail_count++;
            $display("MISMATCH red_leds expected %h actual %h", expected, actual);
        end
    endtask

    task automatic check_green(logic [green_width-1:0] expected,
                               logic [green_width-1:0] actual);
        if (expected === actual)
        begin
            pass_count++;
            $display("ok green_leds %h", actual);
        end
        else
        begin
            fail_count++;
            $display("MISMATCH green_leds expected %h actual %h", expected, actual);
        end
    endtask

    // one address phase; hwdata belongs to the previous transfer
    task automatic issue(htrans_t trans, logic [2:0] size, logic [31:0] addr, logic wr,
                         logic [31:0] wdata, logic chk, logic [31:0] expected, string name);
        @(posedge clk);
        #1;
        hwdata     = next_wdata;
        haddr      = ahb_addr_t'(addr);
        htrans     = trans;
        hsize      = hsize_t'(size);
        hwrite     = wr;
        next_wdata = wdata;
        if (chk)
        begin
            exp_q.push_back(expected);
            cyc_q.push_back(cycle);
            name_q.push_back(name);
        end
    endtask

    always @(posedge clk)
    begin
        cycle++;
    end

    // stops a run that takes far longer than the vectors need
    initial
    begin
        wait (cycle > limit);
        $display("run timed out after %0d cycles", cycle);
        $display("=== FAIL ===");
        $finish;
    end

    always @(negedge clk)
    begin
        while (cyc_q.size() > 0 && cyc_q[0] < cycle)
        begin
            check_rdata(name_q.pop_front(), exp_q.pop_front(), hrdata);
            void'(cyc_q.pop_front());
        end
    end

    initial
    begin
        int          fd;
        int          n;
        int          transfers;
        string       line;
        logic [3:0]  op;
        logic [2:0]  size;
        logic [31:0] addr;
        logic [31:0] data;
        logic [31:0] expv;
        logic [31:0] w;

        rst_n      = 1'b0;
        haddr      = ahb_addr_t'(32'h0);
        htrans     = htrans_idle;
        hsize      = hsize_word;
        hwrite     = 1'b0;
        hwdata     = 32'h0;
        switches   = '0;
        buttons    = '0;
        next_wdata = 32'h0;
        lfsr_state = 16'd35;
        cycle      = 0;
        limit      = 1000000;
        pass_count = 0;
        fail_count = 0;
        transfers  = 0;

        fd = $fopen("verification/mfp_ahb_vectors.txt", "r");
        if (fd == 0)
        begin
            $display("could not open the vector file");
            fail_count++;
        end
        else
        begin
            while (!$feof(fd))
            begin
                line = "";
                void'($fgets(line, fd));
                if (line.len() > 2 && line[0] != 8'h2F)
                begin
                    n = $sscanf(line, "%h %h %h %h %h", op, size, addr, data, expv);
                    if (n == 5)
                    begin
                        v_op.push_back(op);
                        v_size.push_back(size);
                        v_addr.push_back(addr);
                        v_data.push_back(data);
                        v_exp.push_back(expv);
                        // fill and block read carry their count in data
                        transfers += (op == 4'h3 || op == 4'h7) ? int'(data) : 1;
                    end
                end
            end
            $fclose(fd);
        end
        limit = transfers * 4 + 200;

        repeat (10) @(posedge clk);
        #1;
        rst_n = 1'b1;

        foreach (v_op[i])
        begin
            op   = v_op[i];
            size = v_size[i];
            addr = v_addr[i];
            data = v_data[i];
            expv = v_exp[i];
            case (op)
                4'h0:
                begin
                    if (is_ram(addr))
                        model[addr[11:2]] = apply_write(model[addr[11:2]], data, size,
                                                        addr[1:0]);
                    issue(htrans_nonseq, size, addr, 1'b1, data, 1'b0, 32'h0, "");
                end
                4'h1:
                    issue(htrans_nonseq, size, addr, 1'b0, 32'h0, 1'b1, expv,
                          $sformatf("read %h", addr));
                4'h2:
                begin
                    issue(htrans_idle, 3'd2, 32'h0, 1'b0, 32'h0, 1'b1, 32'h0, "idle");
                    switches = data[switch_width-1:0];
                    buttons  = addr[button_width-1:0];
                end
                4'h3:
                begin
                    for (int k = 0; k < int'(data); k++)
                    begin
                        w = random_word();
                        model[(addr[11:2] + k) % 1024] = w;
                        issue(htrans_seq, 3'd2, addr + 4 * k, 1'b1, w, 1'b0, 32'h0, "");
                    end
                end
                4'h4:
                    issue(htrans_idle, size, addr, 1'b1, data, 1'b1, 32'h0, "idle");
                4'h5:
                    issue(htrans_nonseq, 3'd2, addr, 1'b0, 32'h0, 1'b1, model[addr[11:2]],
                          $sformatf("model %h", addr));
                4'h6:
                begin
                    // let the last write finish its data phase
                    issue(htrans_idle, 3'd2, 32'h0, 1'b0, 32'h0, 1'b0, 32'h0, "");
                    issue(htrans_idle, 3'd2, 32'h0, 1'b0, 32'h0, 1'b0, 32'h0, "");
                    @(negedge clk);
                    check_red(data[red_width-1:0], red_leds);
                    check_green(expv[green_width-1:0], green_leds);
                end
                4'h7:
                begin
                    for (int k = 0; k < int'(data); k++)
                        issue(htrans_seq, 3'd2, addr + 4 * k, 1'b0, 32'h0, 1'b1,
                              model[(addr[11:2] + k) % 1024],
                              $sformatf("fill %h", addr + 4 * k));
                end
                default:
                begin
                    $display("unknown operation code %h in vector %0d", op, i);
                    fail_count++;
                end
            endcase
        end

        issue(htrans_idle, 3'd2, 32'h0, 1'b0, 32'h0, 1'b0, 32'h0, "");
        issue(htrans_idle, 3'd2, 32'h0, 1'b0, 32'h0, 1'b0, 32'h0, "");
        repeat (2) @(posedge clk);

        $display("checks passed %0d failed %0d", pass_count, fail_count);
        if (fail_count == 0)
            $display("=== PASS ===");
        else
            $display("=== FAIL ===");
        $finish;
    end

endmodule

//--- design/mfp_ahb_system.sv
module mfp_ahb_system
    import mfp_ahb_pkg::*;
#(
    parameter int ram_addr_width = 10
)
(
    input  logic                    clk,
    input  logic                    rst_n,
    input  ahb_addr_t               haddr,
    input  htrans_t                 htrans,
    input  hsize_t                  hsize,
    input  logic                    hwrite,
    input  logic [31:0]             hwdata,
    output logic [31:0]             hrdata,
    input  logic [switch_width-1:0] switches,
    input  logic [button_width-1:0] buttons,
    output logic [red_width-1:0]    red_leds,
    output logic [green_width-1:0]  green_leds
);

    logic        hsel_ram;
    logic        hsel_gpio;
    logic [31:0] ram_rdata;
    logic [31:0] gpio_rdata;

    mfp_ahb_matrix i_matrix
    (
        .clk        ( clk        ),
        .rst_n      ( rst_n      ),
        .haddr      ( haddr      ),
        .htrans     ( htrans     ),
        .ram_rdata  ( ram_rdata  ),
        .gpio_rdata ( gpio_rdata ),
        .hsel_ram   ( hsel_ram   ),
        .hsel_gpio  ( hsel_gpio  ),
        .hrdata     ( hrdata     )
    );

    mfp_ahb_ram #(
        .ram_addr_width ( ram_addr_width )
    ) i_ram
    (
        .clk    ( clk       ),
        .rst_n  ( rst_n     ),
        .hsel   ( hsel_ram  ),
        .haddr  ( haddr     ),
        .hsize  ( hsize     ),
        .hwrite ( hwrite    ),
        .hwdata ( hwdata    ),
        .rdata  ( ram_rdata )
    );

    // board switches, buttons and leds
    mfp_ahb_gpio i_gpio
    (
        .clk        ( clk        ),
        .rst_n      ( rst_n      ),
        .hsel       ( hsel_gpio  ),
        .haddr      ( haddr      ),
        .hsize      ( hsize      ),
        .hwrite     ( hwrite     ),
        .hwdata     ( hwdata     ),
        .rdata      ( gpio_rdata ),
        .switches   ( switches   ),
        .buttons    ( buttons    ),
        .red_leds   ( red_leds   ),
        .green_leds ( green_leds )
    );

endmodule

//--- design/mfp_ahb_matrix.sv
module mfp_ahb_matrix
    import mfp_ahb_pkg::*;
(
    input  logic        clk,
    input  logic        rst_n,
    input  ahb_addr_t   haddr,
    input  htrans_t     htrans,
    input  logic [31:0] ram_rdata,
    input  logic [31:0] gpio_rdata,
    output logic        hsel_ram,
    output logic        hsel_gpio,
    output logic [31:0] hrdata
);

    logic        active;
    logic [11:0] region;
    logic        sel_ram_q;
    logic        sel_gpio_q;

    // idle and busy carry no transfer
    assign active = (htrans == htrans_nonseq) || (htrans == htrans_seq);

    // region field sits at the same place in both views
    assign region = haddr.ram.region;

    assign hsel_ram  = active && (region == ram_region);
    assign hsel_gpio = active && (region == gpio_region);

    // data phase select, follows every address phase
    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            sel_ram_q  <= 1'b0;
            sel_gpio_q <= 1'b0;
        end
        else
        begin
            sel_ram_q  <= hsel_ram;
            sel_gpio_q <= hsel_gpio;
        end
    end

    // unmapped or idle reads back as zero
    always_comb
    begin
        if (sel_ram_q)
            hrdata = ram_rdata;
        else if (sel_gpio_q)
            hrdata = gpio_rdata;
        else
            hrdata = 32'b0;
    end

endmodule

//--- design/mfp_ahb_gpio.sv
module mfp_ahb_gpio
    import mfp_ahb_pkg::*;
(
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    hsel,
    input  ahb_addr_t               haddr,
    input  hsize_t                  hsize,
    input  logic                    hwrite,
    input  logic [31:0]             hwdata,
    output logic [31:0]             rdata,
    input  logic [switch_width-1:0] switches,
    input  logic [button_width-1:0] buttons,
    output logic [red_width-1:0]    red_leds,
    output logic [green_width-1:0]  green_leds
);

    logic                    wr_pending;
    logic [1:0]              wr_sel;
    logic [3:0]              wr_mask;
    logic [1:0]              rd_sel;
    logic [switch_width-1:0] sw_meta;
    logic [switch_width-1:0] sw_sync;
    logic [switch_width-1:0] sw_reg;
    logic [button_width-1:0] btn_meta;
    logic [button_width-1:0] btn_sync;
    logic [button_width-1:0] btn_reg;
    logic [31:0]             red_next;
    logic [31:0]             green_next;

    assign red_next   = ahb_lane_merge(32'(red_leds), hwdata, wr_mask);
    assign green_next = ahb_lane_merge(32'(green_leds), hwdata, wr_mask);

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            wr_pending <= 1'b0;
            wr_sel     <= 2'b0;
            wr_mask    <= 4'b0;
            rd_sel     <= 2'b0;
            red_leds   <= '0;
            green_leds <= '0;
            sw_meta    <= '0;
            sw_sync    <= '0;
            sw_reg     <= '0;
            btn_meta   <= '0;
            btn_sync   <= '0;
            btn_reg    <= '0;
        end
        else
        begin
            // address phase
            wr_pending <= hsel && hwrite;
            if (hsel)
            begin
                wr_sel  <= haddr.gpio.reg_sel;
                wr_mask <= ahb_lane_mask(hsize, haddr.gpio.byte_off);
                rd_sel  <= haddr.gpio.reg_sel;
            end

            // data phase, switch and button registers ignore writes
            if (wr_pending && wr_sel == gpio_sel_red)
                red_leds <= red_next[red_width-1:0];
            if (wr_pending && wr_sel == gpio_sel_green)
                green_leds <= green_next[green_width-1:0];

            // two sync flops then the read register
            sw_meta  <= switches;
            sw_sync  <= sw_meta;
            sw_reg   <= sw_sync;
            btn_meta <= buttons;
            btn_sync <= btn_meta;
            btn_reg  <= btn_sync;
        end
    end

    always_comb
    begin
        case (rd_sel)
            gpio_sel_red:      rdata = 32'(red_leds);
            gpio_sel_green:    rdata = 32'(green_leds);
            gpio_sel_switches: rdata = 32'(sw_reg);
            default:           rdata = 32'(btn_reg);
        endcase
    end

endmodule

//--- design/mfp_ahb_ram.sv
module mfp_ahb_ram
    import mfp_ahb_pkg::*;
#(
    parameter int ram_addr_width = 10
)
(
    input  logic        clk,
    input  logic        rst_n,
    input  logic        hsel,
    input  ahb_addr_t   haddr,
    input  hsize_t      hsize,
    input  logic        hwrite,
    input  logic [31:0] hwdata,
    output logic [31:0] rdata
);

    logic [31:0] mem [0:(1 << ram_addr_width) - 1];

    logic [ram_addr_width-1:0] index;
    logic                      wr_pending;
    logic [ram_addr_width-1:0] wr_addr;
    logic [3:0]                wr_mask;
    logic [31:0]               rd_word;
    logic [31:0]               fwd_data;
    logic [3:0]                fwd_mask;

    // low bits of the word index only
    assign index = haddr.ram.word_index[ram_addr_width-1:0];

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            wr_pending <= 1'b0;
            fwd_mask   <= 4'b0;
        end
        else
        begin
            wr_pending <= hsel && hwrite;
            // read of the word whose write is in its data phase right now
            if (hsel && !hwrite)
                fwd_mask <= (wr_pending && wr_addr == index) ? wr_mask : 4'b0;
        end
    end

    always_ff @(posedge clk)
    begin
        if (hsel && hwrite)
        begin
            wr_addr <= index;
            wr_mask <= ahb_lane_mask(hsize, haddr.ram.byte_off);
        end
        if (hsel && !hwrite)
        begin
            rd_word  <= mem[index];
            fwd_data <= hwdata;
        end
    end

    // data phase write, byte enables
    always_ff @(posedge clk)
    begin
        if (wr_pending)
        begin
            for (int i = 0; i < 4; i++)
            begin
                if (wr_mask[i])
                    mem[wr_addr][8*i +: 8] <= hwdata[8*i +: 8];
            end
        end
    end

    assign rdata = ahb_lane_merge(rd_word, fwd_data, fwd_mask);

endmodule

//--- design/mfp_ahb_pkg.sv
`include "mfp_ahb_map.svh"

package mfp_ahb_pkg;

    typedef enum logic [1:0] {
        htrans_idle   = 2'b00,
        htrans_busy   = 2'b01,
        htrans_nonseq = 2'b10,
        htrans_seq    = 2'b11
    } htrans_t;

    typedef enum logic [2:0] {
        hsize_byte = 3'b000,
        hsize_half = 3'b001,
        hsize_word = 3'b010
    } hsize_t;

    // ram view of haddr
    typedef struct packed {
        logic [11:0] region;
        logic [17:0] word_index;
        logic [1:0]  byte_off;
    } ram_view_t;

    // gpio view of the same haddr
    typedef struct packed {
        logic [11:0] region;
        logic [15:0] unused;
        logic [1:0]  reg_sel;
        logic [1:0]  byte_off;
    } gpio_view_t;

    typedef union packed {
        ram_view_t  ram;
        gpio_view_t gpio;
    } ahb_addr_t;

    localparam int red_width    = 18;
    localparam int green_width  = 9;
    localparam int switch_width = 18;
    localparam int button_width = 5;

    localparam logic [11:0] ram_region  = 12'(`MFP_RAM_BASE >> `MFP_REGION_LSB);
    localparam logic [11:0] gpio_region = 12'(`MFP_GPIO_BASE >> `MFP_REGION_LSB);

    localparam logic [1:0] gpio_sel_red      = 2'(`MFP_GPIO_RED >> 2);
    localparam logic [1:0] gpio_sel_green    = 2'(`MFP_GPIO_GREEN >> 2);
    localparam logic [1:0] gpio_sel_switches = 2'(`MFP_GPIO_SWITCHES >> 2);
    localparam logic [1:0] gpio_sel_buttons  = 2'(`MFP_GPIO_BUTTONS >> 2);

    // little endian byte lanes
    function automatic logic [3:0] ahb_lane_mask(hsize_t size, logic [1:0] byte_off);
        case (size)
            hsize_byte: return 4'b0001 << byte_off;
            hsize_half: return byte_off[1] ? 4'b1100 : 4'b0011;
            default:    return 4'b1111;
        endcase
    endfunction

    // replace the masked lanes of old_word with new_word
    function automatic logic [31:0] ahb_lane_merge(logic [31:0] old_word,
                                                   logic [31:0] new_word,
                                                   logic [3:0]  mask);
        logic [31:0] result;
        result = old_word;
        for (int i = 0; i < 4; i++)
        begin
            if (mask[i])
                result[8*i +: 8] = new_word[8*i +: 8];
        end
        return result;
    endfunction

endpackage

//--- include/mfp_ahb_map.svh
`ifndef MFP_AHB_MAP_SVH
`define MFP_AHB_MAP_SVH

// region base addresses, region is haddr[31:20]
`define MFP_RAM_BASE        32'h0000_0000
`define MFP_GPIO_BASE       32'h1F80_0000

// gpio register offsets within the gpio region
`define MFP_GPIO_RED        32'h0000_0000
`define MFP_GPIO_GREEN      32'h0000_0004
`define MFP_GPIO_SWITCHES   32'h0000_0008
`define MFP_GPIO_BUTTONS    32'h0000_000C

// region field position
`define MFP_REGION_LSB      20

`endif
